//--- hw/reorder_pkg.sv
/*
 * Shared types and widths for the reorder engine.
 * Every RTL block that needs the data width or an enum imports this package.
 */

package reorder_pkg;

  // Operand and result width
  localparam int data_width = 16;

  // Arithmetic opcodes carried on the request port
  typedef enum logic [1:0] {
    // a + b
    op_add = 2'd0,
    // a - b
    op_sub = 2'd1,
    // a ^ b
    op_xor = 2'd2,
    // Low half of a * b
    op_mul = 2'd3
  } op_e;

  // Life cycle of one execution slot
  typedef enum logic [1:0] {
    // Free to take a new operation
    slot_idle = 2'd0,
    // Counting down the opcode latency
    slot_busy = 2'd1,
    // Result ready and waiting for the completion port
    slot_done = 2'd2
  } slot_state_e;

endpackage

//--- hw/tracker_reorder.sv
/*
 * Tag tracker. Hands out tags in order, collects out-of-order completions
 * and releases tags in allocation order. A tag comes back on the alloc
 * port only after its release has been taken.
 */

module tracker_reorder
  import reorder_pkg::*;
#(
  parameter int num_entries = 8
) (
  input  logic clk,
  input  logic rst,

  // Allocation port
  input  logic alloc_ready,
  output logic alloc_valid,
  output logic [((num_entries > 1) ? $clog2(num_entries) : 1)-1:0] alloc_entry_id,

  // Completion port, always absorbed
  input  logic dealloc_valid,
  input  logic [((num_entries > 1) ? $clog2(num_entries) : 1)-1:0] dealloc_entry_id,

  // In-order release port
  input  logic dealloc_complete_ready,
  output logic dealloc_complete_valid,
  output logic [((num_entries > 1) ? $clog2(num_entries) : 1)-1:0] dealloc_complete_entry_id
);

  // Tag width, at least one bit
  localparam int tag_w = (num_entries > 1) ? $clog2(num_entries) : 1;
  // Free count must reach num_entries itself
  localparam int count_w = $clog2(num_entries + 1);

  // Next tag to hand out
  logic [tag_w-1:0] alloc_ptr;
  // Oldest outstanding tag, the release head
  logic [tag_w-1:0] release_ptr;
  // Tags not yet allocated or already released
  logic [count_w-1:0] free_count;
  // One bit per tag, set once its completion has arrived
  logic [num_entries-1:0] pending;

  logic alloc_beat;
  logic release_beat;

  assign alloc_beat   = alloc_valid && alloc_ready;
  assign release_beat = dealloc_complete_valid && dealloc_complete_ready;

  // Allocation stalls only when every tag is outstanding
  assign alloc_valid    = (free_count != '0);
  assign alloc_entry_id = alloc_ptr;

  // Head is released only after its own completion, which restores order
  assign dealloc_complete_valid    = pending[release_ptr];
  assign dealloc_complete_entry_id = release_ptr;

  // Allocation counter, wraps at num_entries
  always_ff @(posedge clk) begin
    if (rst) begin
      alloc_ptr <= '0;
    end else if (alloc_beat) begin
      if (alloc_ptr == tag_w'(num_entries - 1)) begin
        alloc_ptr <= '0;
      end else begin
        alloc_ptr <= alloc_ptr + 1'b1;
      end
    end
  end

  // Release counter, same wrap rule
  always_ff @(posedge clk) begin
    if (rst) begin
      release_ptr <= '0;
    end else if (release_beat) begin
      if (release_ptr == tag_w'(num_entries - 1)) begin
        release_ptr <= '0;
      end else begin
        release_ptr <= release_ptr + 1'b1;
      end
    end
  end

  // Free count drops on allocation, rises on release
  always_ff @(posedge clk) begin
    if (rst) begin
      free_count <= count_w'(num_entries);
    end else begin
      case ({alloc_beat, release_beat})
        2'b10:   free_count <= free_count - 1'b1;
        2'b01:   free_count <= free_count + 1'b1;
        default: free_count <= free_count;
      endcase
    end
  end

  // Pending bitmap
  // A tag cannot complete and release in the same cycle, set wins anyway
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else begin
      for (int i = 0; i < num_entries; i++) begin
        if (dealloc_valid && (dealloc_entry_id == tag_w'(i))) begin
          pending[i] <= 1'b1;
        end else if (release_beat && (release_ptr == tag_w'(i))) begin
          pending[i] <= 1'b0;
        end
      end
    end
  end

endmodule

//--- hw/ooo_exec_unit.sv
/*
 * Multi-slot execution unit. Each slot computes its result at acceptance,
 * waits out the opcode latency, then competes for the single completion
 * port under a rotating priority. Completions are never stalled.
 */

module ooo_exec_unit
  import reorder_pkg::*;
#(
  parameter int num_entries = 8,
  parameter int exec_slots  = 4
) (
  input  logic clk,
  input  logic rst,

  // Issue port
  input  logic in_valid,
  output logic in_ready,
  input  op_e  in_op,
  input  logic [data_width-1:0] in_a,
  input  logic [data_width-1:0] in_b,
  input  logic [((num_entries > 1) ? $clog2(num_entries) : 1)-1:0] in_tag,

  // Completion port, no ready
  output logic done_valid,
  output logic [((num_entries > 1) ? $clog2(num_entries) : 1)-1:0] done_tag,
  output logic [data_width-1:0] done_result
);

  localparam int tag_w  = (num_entries > 1) ? $clog2(num_entries) : 1;
  localparam int slot_w = (exec_slots > 1) ? $clog2(exec_slots) : 1;

  // Latencies in cycles from acceptance to eligibility
  localparam int lat_alu = 1;
  localparam int lat_mul = 4;
  localparam int cnt_w   = $clog2(lat_mul + 1);

  // Per-slot state
  slot_state_e            slot_state  [exec_slots];
  logic [cnt_w-1:0]       slot_cnt    [exec_slots];
  logic [tag_w-1:0]       slot_tag    [exec_slots];
  logic [data_width-1:0]  slot_result [exec_slots];

  // Issue side decode
  logic                  in_beat;
  logic [data_width-1:0] in_result;
  logic [cnt_w-1:0]      in_lat;
  logic                  idle_found;
  logic [slot_w-1:0]     idle_idx;

  // Completion side arbitration
  logic [slot_w-1:0] rr_ptr;
  logic              pick_valid;
  logic [slot_w-1:0] pick_idx;

  assign in_ready = idle_found;
  assign in_beat  = in_valid && in_ready;

  // Result is fixed at acceptance, only the latency is modelled afterwards
  always_comb begin
    case (in_op)
      op_add:  in_result = in_a + in_b;
      op_sub:  in_result = in_a - in_b;
      op_xor:  in_result = in_a ^ in_b;
      default: in_result = in_a * in_b;
    endcase
    in_lat = (in_op == op_mul) ? cnt_w'(lat_mul) : cnt_w'(lat_alu);
  end

  // Lowest idle slot takes the next operation
  always_comb begin
    idle_found = 1'b0;
    idle_idx   = '0;
    for (int s = 0; s < exec_slots; s++) begin
      if (!idle_found && (slot_state[s] == slot_idle)) begin
        idle_found = 1'b1;
        idle_idx   = slot_w'(s);
      end
    end
  end

  // First done slot at or after the rotating pointer
  always_comb begin
    int unsigned idx;
    pick_valid = 1'b0;
    pick_idx   = '0;
    for (int k = 0; k < exec_slots; k++) begin
      idx = (int'(rr_ptr) + k) % exec_slots;
      if (!pick_valid && (slot_state[idx] == slot_done)) begin
        pick_valid = 1'b1;
        pick_idx   = slot_w'(idx);
      end
    end
  end

  // Slot state and countdown
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < exec_slots; s++) begin
        slot_state[s] <= slot_idle;
        slot_cnt[s]   <= '0;
      end
    end else begin
      for (int s = 0; s < exec_slots; s++) begin
        if (in_beat && (idle_idx == slot_w'(s))) begin
          // Single-cycle ops are eligible on the very next cycle
          slot_state[s] <= (in_lat == cnt_w'(1)) ? slot_done : slot_busy;
          slot_cnt[s]   <= in_lat - 1'b1;
        end else if (slot_state[s] == slot_busy) begin
          if (slot_cnt[s] == cnt_w'(1)) begin
            slot_state[s] <= slot_done;
          end
          slot_cnt[s] <= slot_cnt[s] - 1'b1;
        end else if (pick_valid && (pick_idx == slot_w'(s))) begin
          slot_state[s] <= slot_idle;
        end
      end
    end
  end

  // Slot payload
  always_ff @(posedge clk) begin
    if (in_beat) begin
      slot_tag[idle_idx]    <= in_tag;
      slot_result[idle_idx] <= in_result;
    end
  end

  // Pointer moves past the slot just served
  always_ff @(posedge clk) begin
    if (rst) begin
      rr_ptr <= '0;
    end else if (pick_valid) begin
      if (pick_idx == slot_w'(exec_slots - 1)) begin
        rr_ptr <= '0;
      end else begin
        rr_ptr <= pick_idx + 1'b1;
      end
    end
  end

  // Registered completion port
  always_ff @(posedge clk) begin
    if (rst) begin
      done_valid <= 1'b0;
    end else begin
      done_valid <= pick_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (pick_valid) begin
      done_tag    <= slot_tag[pick_idx];
      done_result <= slot_result[pick_idx];
    end
  end

endmodule

//--- hw/result_buffer.sv
/*
 * Result storage indexed by tag. Completions write their entry, and the
 * release head reads its entry combinationally for the response port.
 */

module result_buffer
  import reorder_pkg::*;
#(
  parameter int num_entries = 8
) (
  input  logic clk,
  input  logic rst,

  // Write port, driven by the completion path
  input  logic wr_valid,
  input  logic [((num_entries > 1) ? $clog2(num_entries) : 1)-1:0] wr_tag,
  input  logic [data_width-1:0] wr_data,

  // Read port at the release head
  input  logic [((num_entries > 1) ? $clog2(num_entries) : 1)-1:0] rd_tag,
  output logic [data_width-1:0] rd_data
);

  // One result word per tag
  logic [data_width-1:0] entries [num_entries];

  // Entry is safe to overwrite only after the tracker frees its tag
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_entries; i++) begin
        entries[i] <= '0;
      end
    end else if (wr_valid) begin
      entries[wr_tag] <= wr_data;
    end
  end

  // Combinational read, no added latency on release
  assign rd_data = entries[rd_tag];

endmodule

//--- hw/reorder_core.sv
/*
 * Top level of the reorder engine. Requests take a tag and an execution
 * slot together, results return out of order into the result buffer, and
 * responses leave in request order.
 */

module reorder_core
  import reorder_pkg::*;
#(
  // Number of tags in flight
  parameter int num_entries = 8,
  // Number of operations held by the execution unit
  parameter int exec_slots  = 4
) (
  input  logic clk,
  input  logic rst,

  // Request port
  input  logic req_valid,
  output logic req_ready,
  input  op_e  req_op,
  input  logic [data_width-1:0] req_a,
  input  logic [data_width-1:0] req_b,

  // Response port
  output logic resp_valid,
  input  logic resp_ready,
  output logic [data_width-1:0] resp_result
);

  localparam int tag_w = (num_entries > 1) ? $clog2(num_entries) : 1;

  // Allocation side
  logic             alloc_valid;
  logic [tag_w-1:0] alloc_entry_id;
  logic             in_ready;
  logic             accept;

  // Completion side
  logic                  done_valid;
  logic [tag_w-1:0]      done_tag;
  logic [data_width-1:0] done_result;

  // Release side
  logic             release_valid;
  logic [tag_w-1:0] release_tag;

  // A request needs both a free tag and an idle slot
  assign req_ready = alloc_valid && in_ready;
  assign accept    = req_valid && req_ready;

  tracker_reorder #(
    .num_entries(num_entries)
  ) u_tracker (
    .clk                      (clk),
    .rst                      (rst),
    .alloc_ready              (accept),
    .alloc_valid              (alloc_valid),
    .alloc_entry_id           (alloc_entry_id),
    .dealloc_valid            (done_valid),
    .dealloc_entry_id         (done_tag),
    .dealloc_complete_ready   (resp_ready),
    .dealloc_complete_valid   (release_valid),
    .dealloc_complete_entry_id(release_tag)
  );

  ooo_exec_unit #(
    .num_entries(num_entries),
    .exec_slots (exec_slots)
  ) u_exec (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (accept),
    .in_ready   (in_ready),
    .in_op      (req_op),
    .in_a       (req_a),
    .in_b       (req_b),
    .in_tag     (alloc_entry_id),
    .done_valid (done_valid),
    .done_tag   (done_tag),
    .done_result(done_result)
  );

  // Completions land here in the same cycle the tracker sees them
  result_buffer #(
    .num_entries(num_entries)
  ) u_results (
    .clk     (clk),
    .rst     (rst),
    .wr_valid(done_valid),
    .wr_tag  (done_tag),
    .wr_data (done_result),
    .rd_tag  (release_tag),
    .rd_data (resp_result)
  );

  // Release head drives the response directly
  assign resp_valid = release_valid;

endmodule

//--- tests/tb_reorder_tasks.svh
/*
 * Directed tests, random source and bounded waits of the reorder testbench.
 * Included inside the testbench module, uses its signals and queue.
 */

  // One xorshift32 step
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Advances the shared stream
  function automatic logic [31:0] random_word();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Next drive point, 0.5 ns after the rising edge
  task automatic step_cycle();
    @(posedge clk);
    #0.5;
  endtask

  // Holds a request until taken, queues its expected result
  task automatic send_request(input op_e op, input logic [data_width-1:0] a,
                              input logic [data_width-1:0] b);
    int waited;
    waited    = 0;
    req_valid = 1'b1;
    req_op    = op;
    req_a     = a;
    req_b     = b;
    while ((req_ready !== 1'b1) && (waited < wait_limit)) begin
      step_cycle();
      waited++;
    end
    assert (req_ready === 1'b1) else begin
      $display("Timeout: request not accepted within %0d cycles", wait_limit);
      timeout_errors++;
    end
    if (req_ready === 1'b1) begin
      expect_q.push_back(expected_result(op, a, b));
      step_cycle();
    end
    req_valid = 1'b0;
  endtask

  // Takes responses until nothing is owed
  task automatic wait_drained(input int limit);
    int waited;
    waited     = 0;
    resp_ready = 1'b1;
    while ((expect_q.size() != 0) && (waited < limit)) begin
      step_cycle();
      waited++;
    end
    assert (expect_q.size() == 0) else begin
      $display("Timeout: %0d responses still missing after %0d cycles",
               expect_q.size(), limit);
      timeout_errors++;
    end
  endtask

  task automatic check_reset_state();
    assert (req_ready === 1'b1) else begin
      $display("[FAIL] req_ready expected 0x1 got 0x%h", req_ready);
      value_errors++;
    end
    assert (resp_valid === 1'b0) else begin
      $display("[FAIL] resp_valid expected 0x0 got 0x%h", resp_valid);
      value_errors++;
    end
  endtask

  // Each opcode alone, second pair wraps the sum and borrows on sub
  task automatic run_opcode_results();
    resp_ready = 1'b1;
    for (int i = 0; i < 4; i++) begin
      send_request(op_e'(2'(i)), 16'hc35a, 16'h1e0f);
      wait_drained(wait_limit);
      send_request(op_e'(2'(i)), 16'h0017, 16'hfff3);
      wait_drained(wait_limit);
    end
  endtask

  // Slow multiply ahead of three fast adds
  task automatic run_ordering();
    int start_count;
    start_count = resp_count;
    resp_ready  = 1'b1;
    send_request(op_mul, 16'h0123, 16'h0456);
    send_request(op_add, 16'h1000, 16'h0001);
    send_request(op_add, 16'h2000, 16'h0002);
    send_request(op_add, 16'h3000, 16'h0003);
    wait_drained(wait_limit);
    assert ((resp_count - start_count) == 4) else begin
      $display("Ordering test took %0d responses instead of 4", resp_count - start_count);
      value_errors++;
    end
  endtask

  // Fill the engine with responses blocked, then drain
  task automatic run_backpressure();
    int accepted;
    int low_run;
    int cycles;
    accepted   = 0;
    low_run    = 0;
    cycles     = 0;
    resp_ready = 1'b0;
    // 12 low cycles outlast any slot stall, so the tags are exhausted
    while ((low_run < 12) && (cycles < wait_limit)) begin
      if (req_ready === 1'b1) begin
        req_valid = 1'b1;
        req_op    = accepted[0] ? op_mul : op_add;
        req_a     = 16'h0100 + 16'(accepted);
        req_b     = 16'h5003;
        expect_q.push_back(expected_result(req_op, req_a, req_b));
        accepted++;
        low_run = 0;
      end else begin
        req_valid = 1'b0;
        low_run++;
      end
      step_cycle();
      cycles++;
    end
    req_valid = 1'b0;
    assert (low_run >= 12) else begin
      $display("Timeout: req_ready kept returning under back-pressure");
      timeout_errors++;
    end
    assert ((accepted >= exec_slots) && (accepted <= num_entries)) else begin
      $display("Back-pressure test accepted %0d requests, outside %0d to %0d",
               accepted, exec_slots, num_entries);
      value_errors++;
    end
    wait_drained(wait_limit);
  endtask

  // Random ops, operands, gaps and response stalls
  task automatic run_random_stream();
    int          sent;
    int          gap;
    int          cycles;
    logic [31:0] rnd;
    logic [31:0] operands;
    logic        accepted;
    sent   = 0;
    gap    = 0;
    cycles = 0;
    while ((sent < random_count) && (cycles < random_count * 40)) begin
      rnd        = random_word();
      // Ready three cycles out of four on average
      resp_ready = (rnd[1:0] != 2'b00);
      if (req_valid !== 1'b1) begin
        if (gap != 0) begin
          gap--;
        end else begin
          operands  = random_word();
          req_valid = 1'b1;
          req_op    = op_e'(rnd[9:8]);
          req_a     = operands[31:16];
          req_b     = operands[15:0];
        end
      end
      accepted = (req_valid === 1'b1) && (req_ready === 1'b1);
      if (accepted) begin
        expect_q.push_back(expected_result(req_op, req_a, req_b));
        sent++;
        gap = int'(rnd[5:4]);
      end
      step_cycle();
      cycles++;
      if (accepted) begin
        req_valid = 1'b0;
      end
    end
    req_valid = 1'b0;
    assert (sent == random_count) else begin
      $display("Timeout: random stream sent only %0d of %0d requests", sent, random_count);
      timeout_errors++;
    end
    wait_drained(wait_limit * 4);
  endtask

//--- tests/tb_reorder_core.sv
/*
 * Testbench for the reorder engine. Drives the request port, keeps the
 * expected results in a queue and checks every response in request order.
 * The directed tests come from the included task file.
 */

module tb_reorder_core
  import reorder_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_entries  = 8;
  localparam int exec_slots   = 4;
  // Requests in the random stream
  localparam int random_count = 200;
  // Default bound for every wait loop, in cycles
  localparam int wait_limit   = 200;

  logic                  clk;
  logic                  rst;
  logic                  req_valid;
  logic                  req_ready;
  op_e                   req_op;
  logic [data_width-1:0] req_a;
  logic [data_width-1:0] req_b;
  logic                  resp_valid;
  logic                  resp_ready;
  logic [data_width-1:0] resp_result;

  // Results still owed by the DUT, oldest first
  logic [data_width-1:0] expect_q [$];
  int                    value_errors;
  int                    timeout_errors;
  int                    resp_count;
  logic [31:0]           rng_state;

  // Response seen but not taken last cycle
  logic                  held_valid;
  logic [data_width-1:0] held_result;

  reorder_core #(
    .num_entries(num_entries),
    .exec_slots (exec_slots)
  ) u_reorder_core (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req_op     (req_op),
    .req_a      (req_a),
    .req_b      (req_b),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp_result(resp_result)
  );

  // 4 ns period
  always #2 clk = ~clk;

  `include "tb_reorder_tasks.svh"

  // Reference model of one operation
  function automatic logic [data_width-1:0] expected_result(input op_e op,
                                                           input logic [data_width-1:0] a,
                                                           input logic [data_width-1:0] b);
    logic [2*data_width-1:0] product;
    product = a * b;
    case (op)
      op_add:  return a + b;
      op_sub:  return a - b;
      op_xor:  return a ^ b;
      default: return product[data_width-1:0];
    endcase
  endfunction

  // Pops the oldest expectation and compares it with a taken response
  task automatic check_response(input logic [data_width-1:0] actual);
    logic [data_width-1:0] expected;
    assert (expect_q.size() != 0) else begin
      $display("Response 0x%h arrived with no request outstanding", actual);
      value_errors++;
    end
    if (expect_q.size() != 0) begin
      expected = expect_q.pop_front();
      assert (actual === expected) else begin
        $display("[FAIL] resp_result expected 0x%h got 0x%h", expected, actual);
        value_errors++;
      end
    end
    resp_count++;
  endtask

  // Response monitor
  // Samples 1.5 ns after the edge, once the stimulus has settled
  always @(posedge clk) begin
    #1.5;
    if (rst) begin
      held_valid = 1'b0;
    end else begin
      // A refused response must stay put
      if (held_valid) begin
        assert (resp_valid === 1'b1) else begin
          $display("[FAIL] resp_valid expected 0x1 got 0x%h", resp_valid);
          value_errors++;
        end
        assert (resp_result === held_result) else begin
          $display("[FAIL] resp_result expected 0x%h got 0x%h", held_result, resp_result);
          value_errors++;
        end
      end
      if ((resp_valid === 1'b1) && (resp_ready === 1'b1)) begin
        check_response(resp_result);
      end
      held_valid  = (resp_valid === 1'b1) && (resp_ready !== 1'b1);
      held_result = resp_result;
    end
  end

  initial begin
    clk            = 1'b0;
    rst            = 1'b1;
    req_valid      = 1'b0;
    req_op         = op_add;
    req_a          = '0;
    req_b          = '0;
    resp_ready     = 1'b0;
    value_errors   = 0;
    timeout_errors = 0;
    resp_count     = 0;
    rng_state      = 32'd6;
    held_valid     = 1'b0;
    held_result    = '0;

    repeat (8) @(posedge clk);
    #0.5;
    rst = 1'b0;

    check_reset_state();
    run_opcode_results();
    run_ordering();
    run_backpressure();
    run_random_stream();

    $display("Responses checked %0d, value errors %0d, timeout errors %0d",
             resp_count, value_errors, timeout_errors);
    if ((value_errors + timeout_errors) == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+tests
hw/reorder_pkg.sv
hw/tracker_reorder.sv
hw/ooo_exec_unit.sv
hw/result_buffer.sv
hw/reorder_core.sv
tests/tb_reorder_core.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the reorder_core testbench with Verilator, runs it and checks the log

set -u

cd "$(dirname "$0")" || exit 1

build_dir="obj_dir"
log_file="sim.log"

verilator --binary --timing -Wno-fatal -f files.f --top-module tb_reorder_core \
  -Mdir "$build_dir" -o sim_reorder
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/sim_reorder" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qF "*** FAILED ***" "$log_file"; then
  echo "Testbench reported failure"
  exit 1
fi

echo "Simulation finished, no failure in $log_file"
exit 0
